// ==== src/dma_settings.svh ====
// DMA copy engine settings
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Bus widths
`define DMA_ADDR_W      32
`define DMA_DATA_W      64
`define DMA_RESP_W      2
`define DMA_APB_ADDR_W  12
`define DMA_APB_DATA_W  32

// Burst limit, 4-bit len on the engine side, 8-bit at the pins
`define DMA_MAX_BURST   16
`define DMA_BLEN_W      4
`define DMA_AXI_LEN_W   8
`define DMA_CNT_W       ($clog2(`DMA_MAX_BURST + 1))

// Job length in beats
`define DMA_LEN_W       16

// Register offsets
`define DMA_REG_SRC     'h00
`define DMA_REG_DST     'h04
`define DMA_REG_LEN     'h08
`define DMA_REG_CTRL    'h0C
`define DMA_REG_STATUS  'h10

`endif

// ==== src/dma_axi_pkg.sv ====
// AXI channel types
`default_nettype none
`include "dma_settings.svh"

package dma_axi_pkg;

  // --------------------------------------------------
  // Response codes
  // --------------------------------------------------
  // Anything else counts as an error
  localparam logic [`DMA_RESP_W-1:0] AXI_RESP_OKAY = '0;

  // --------------------------------------------------
  // Channel payloads
  // --------------------------------------------------
  // AR and AW share one layout
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] addr;
    // Beats minus one
    logic [`DMA_BLEN_W-1:0] len;
  } axi_addr_t;

  // Write data beat
  typedef struct packed {
    logic [`DMA_DATA_W-1:0] data;
    logic                   last;
  } axi_w_t;

  // Read data beat
  typedef struct packed {
    logic [`DMA_DATA_W-1:0] data;
    logic [`DMA_RESP_W-1:0] resp;
    logic                   last;
  } axi_r_t;

  // Write response
  typedef struct packed {
    logic [`DMA_RESP_W-1:0] resp;
  } axi_b_t;

endpackage

`default_nettype wire

// ==== src/dma_ctrl_pkg.sv ====
// DMA control types
`default_nettype none
`include "dma_settings.svh"

package dma_ctrl_pkg;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------
  typedef enum logic [`DMA_APB_ADDR_W-1:0] {
    REG_SRC    = `DMA_APB_ADDR_W'(`DMA_REG_SRC),
    REG_DST    = `DMA_APB_ADDR_W'(`DMA_REG_DST),
    REG_LEN    = `DMA_APB_ADDR_W'(`DMA_REG_LEN),
    REG_CTRL   = `DMA_APB_ADDR_W'(`DMA_REG_CTRL),
    REG_STATUS = `DMA_APB_ADDR_W'(`DMA_REG_STATUS)
  } dma_reg_e;

  // CTRL bit positions
  localparam int CTRL_START_BIT  = 0;
  localparam int CTRL_IRQ_EN_BIT = 1;

  // --------------------------------------------------
  // Engine states
  // --------------------------------------------------
  typedef enum logic [2:0] {
    IDLE,
    RD_ADDR,
    RD_DATA,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } dma_state_e;

  // Job as programmed by software
  typedef struct packed {
    logic [`DMA_ADDR_W-1:0] src;
    logic [`DMA_ADDR_W-1:0] dst;
    logic [`DMA_LEN_W-1:0]  beats;
  } dma_desc_t;

  // STATUS layout, busy in bit 2
  typedef struct packed {
    logic busy;
    logic done;
    logic error;
  } dma_status_t;

endpackage

`default_nettype wire

// ==== src/dma_apb_regs.sv ====
// DMA APB register file
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_apb_regs
  import dma_ctrl_pkg::*;
(
  input  wire logic                       aclk,
  input  wire logic                       reset,
  // APB slave
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [`DMA_APB_ADDR_W-1:0] paddr,
  input  wire logic [`DMA_APB_DATA_W-1:0] pwdata,
  output logic      [`DMA_APB_DATA_W-1:0] prdata,
  output logic                            pready,
  output logic                            pslverr,
  // Engine handshake
  input  wire logic                       busy,
  input  wire logic                       done,
  input  wire logic                       error,
  output logic                            start,
  output dma_desc_t                       desc,
  // Interrupts
  output logic                            irq,
  output logic                            irq_abort
);

  dma_reg_e    reg_sel;
  logic        access;
  logic        mapped;
  logic        cfg_reg;
  logic        wr_en;
  logic        wr_status;
  logic        irq_en;
  logic        done_q;
  logic        error_q;
  dma_status_t status;
  dma_status_t w1c;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  // Access phase only
  assign access  = psel & penable;
  assign reg_sel = dma_reg_e'(paddr);

  always_comb begin
    mapped  = 1'b1;
    cfg_reg = 1'b0;
    case (reg_sel)
      REG_SRC, REG_DST, REG_LEN, REG_CTRL: cfg_reg = 1'b1;
      REG_STATUS: cfg_reg = 1'b0;
      default: mapped = 1'b0;
    endcase
  end

  // Unmapped offset, or config write during a job
  assign pslverr   = access & (~mapped | (pwrite & cfg_reg & busy));
  assign pready    = 1'b1;
  assign wr_en     = access & pwrite & ~pslverr;
  assign wr_status = wr_en & (reg_sel == REG_STATUS);
  assign w1c       = pwdata[$bits(dma_status_t)-1:0];

  // Launch pulse, busy already filtered out by pslverr
  assign start = wr_en & (reg_sel == REG_CTRL) & pwdata[CTRL_START_BIT];

  // --------------------------------------------------
  // Job descriptor
  // --------------------------------------------------
  always_ff @(posedge aclk) begin
    if (wr_en) begin
      case (reg_sel)
        REG_SRC: desc.src <= pwdata;
        REG_DST: desc.dst <= pwdata;
        REG_LEN: desc.beats <= pwdata[`DMA_LEN_W-1:0];
        default: desc <= desc;
      endcase
    end
  end

  // Enable bit and sticky flags
  always_ff @(posedge aclk) begin
    if (reset) begin
      irq_en  <= 1'b0;
      done_q  <= 1'b0;
      error_q <= 1'b0;
    end else begin
      if (wr_en && reg_sel == REG_CTRL) begin
        irq_en <= pwdata[CTRL_IRQ_EN_BIT];
      end
      // New event wins over a clear in the same cycle
      done_q  <= done | (done_q & ~(wr_status & w1c.done));
      error_q <= error | (error_q & ~(wr_status & w1c.error));
    end
  end

  // Live busy level next to the sticky bits
  assign status = '{busy: busy, done: done_q, error: error_q};

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    prdata = '0;
    case (reg_sel)
      REG_SRC:    prdata = desc.src;
      REG_DST:    prdata = desc.dst;
      REG_LEN:    prdata = `DMA_APB_DATA_W'(desc.beats);
      REG_CTRL:   prdata[CTRL_IRQ_EN_BIT] = irq_en;
      REG_STATUS: prdata = `DMA_APB_DATA_W'(status);
      default:    prdata = '0;
    endcase
  end

  assign irq       = done_q & irq_en;
  assign irq_abort = error_q;

endmodule

`default_nettype wire

// ==== src/dma_burst_buffer.sv ====
// DMA burst buffer
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_burst_buffer
  import dma_axi_pkg::*;
(
  input  wire logic                  aclk,
  input  wire logic                  reset,
  input  wire logic                  push,
  input  wire axi_w_t                din,
  input  wire logic                  pop,
  output axi_w_t                     head,
  output logic      [`DMA_CNT_W-1:0] count
);

  // Depth is a power of two, so pointers wrap on their own
  localparam int PTR_W = $clog2(`DMA_MAX_BURST);

  logic [`DMA_DATA_W-1:0] mem [`DMA_MAX_BURST];
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;

  // Storage, data only
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= din.data;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Whole burst sits here before draining, so the final entry is wlast
  assign head.data = mem[rd_ptr];
  assign head.last = (count == 1);

  a_no_overflow: assert property (@(posedge aclk) disable iff (reset)
    push |-> count != `DMA_MAX_BURST);
  a_no_underflow: assert property (@(posedge aclk) disable iff (reset)
    pop |-> count != '0);
  // Slave rlast closes the read phase, nothing more arrives right after
  a_last_closes: assert property (@(posedge aclk) disable iff (reset)
    push && din.last |=> !push);

endmodule

`default_nettype wire

// ==== src/dma_engine.sv ====
// DMA copy engine
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_engine
  import dma_axi_pkg::*, dma_ctrl_pkg::*;
(
  input  wire logic                  aclk,
  input  wire logic                  reset,
  // Register file
  input  wire logic                  start,
  input  wire dma_desc_t             desc,
  output logic                       busy,
  output logic                       done,
  output logic                       error,
  // AXI read
  output axi_addr_t                  ar,
  output logic                       arvalid,
  input  wire logic                  arready,
  input  wire axi_r_t                r,
  input  wire logic                  rvalid,
  output logic                       rready,
  // AXI write
  output axi_addr_t                  aw,
  output logic                       awvalid,
  input  wire logic                  awready,
  output axi_w_t                     w,
  output logic                       wvalid,
  input  wire logic                  wready,
  input  wire axi_b_t                b,
  input  wire logic                  bvalid,
  output logic                       bready,
  // Burst buffer
  output logic                       buf_push,
  output logic                       buf_pop,
  output axi_w_t                     buf_in,
  input  wire axi_w_t                buf_head,
  input  wire logic [`DMA_CNT_W-1:0] buf_count
);

  localparam int CNT_W      = `DMA_CNT_W;
  // Bytes per beat as a shift
  localparam int BEAT_SHIFT = $clog2(`DMA_DATA_W / 8);

  dma_state_e              state;
  logic [`DMA_ADDR_W-1:0]  src_q;
  logic [`DMA_ADDR_W-1:0]  dst_q;
  logic [`DMA_LEN_W-1:0]   remain_q;
  logic [CNT_W-1:0]        rd_cnt;
  logic [CNT_W-1:0]        burst_beats;
  logic [`DMA_BLEN_W-1:0]  burst_len;
  logic [`DMA_ADDR_W-1:0]  burst_bytes;
  logic                    err_q;
  logic                    rd_last;
  logic                    burst_done;

  // --------------------------------------------------
  // Burst split
  // --------------------------------------------------
  // Smaller of remaining and the burst limit
  assign burst_beats = (remain_q > `DMA_LEN_W'(`DMA_MAX_BURST)) ?
                       CNT_W'(`DMA_MAX_BURST) : CNT_W'(remain_q);
  assign burst_len   = `DMA_BLEN_W'(burst_beats - 1'b1);
  assign burst_bytes = `DMA_ADDR_W'(burst_beats) << BEAT_SHIFT;

  // Channel controls straight from state
  assign busy    = (state != IDLE);
  assign arvalid = (state == RD_ADDR);
  assign rready  = (state == RD_DATA);
  assign awvalid = (state == WR_ADDR);
  assign wvalid  = (state == WR_DATA);
  assign bready  = (state == WR_RESP);

  assign ar = '{addr: src_q, len: burst_len};
  assign aw = '{addr: dst_q, len: burst_len};

  // Read beats into the buffer
  assign buf_push = rready & rvalid;
  assign buf_in   = '{data: r.data, last: r.last};
  assign rd_last  = (rd_cnt == burst_beats - 1'b1);

  // Buffer head drives W, wlast regenerated there
  assign w       = buf_head;
  assign buf_pop = wvalid & wready;

  // --------------------------------------------------
  // Job end pulses
  // --------------------------------------------------
  assign burst_done = bready & bvalid;
  assign error = burst_done & (err_q | (b.resp != AXI_RESP_OKAY));
  // Last burst finished clean, or an empty job
  assign done  = (burst_done & ~error & (remain_q == `DMA_LEN_W'(burst_beats))) |
                 ((state == IDLE) & start & (desc.beats == '0));

  // FSM
  always_ff @(posedge aclk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (start && desc.beats != '0) state <= RD_ADDR;
        RD_ADDR: if (arready) state <= RD_DATA;
        RD_DATA: if (buf_push && rd_last) state <= WR_ADDR;
        WR_ADDR: if (awready) state <= WR_DATA;
        WR_DATA: if (buf_pop && buf_head.last) state <= WR_RESP;
        WR_RESP: if (bvalid) state <= (error || done) ? IDLE : RD_ADDR;
        default: state <= IDLE;
      endcase
    end
  end

  // Read error held until the burst's write response
  always_ff @(posedge aclk) begin
    if (reset) begin
      err_q  <= 1'b0;
      rd_cnt <= '0;
    end else begin
      if (burst_done) begin
        err_q <= 1'b0;
      end else if (buf_push && r.resp != AXI_RESP_OKAY) begin
        err_q <= 1'b1;
      end
      if (arvalid && arready) begin
        rd_cnt <= '0;
      end else if (buf_push) begin
        rd_cnt <= rd_cnt + 1'b1;
      end
    end
  end

  // Job pointers load at start and advance per burst
  always_ff @(posedge aclk) begin
    if (state == IDLE && start) begin
      src_q    <= desc.src;
      dst_q    <= desc.dst;
      remain_q <= desc.beats;
    end else if (burst_done) begin
      src_q    <= src_q + burst_bytes;
      dst_q    <= dst_q + burst_bytes;
      remain_q <= remain_q - `DMA_LEN_W'(burst_beats);
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_ar_hold: assert property (@(posedge aclk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(ar));
  // Store-then-write keeps the buffer non-empty for the whole W phase
  a_w_fed: assert property (@(posedge aclk) disable iff (reset)
    wvalid |-> buf_count != '0);
  a_burst_max: assert property (@(posedge aclk) disable iff (reset)
    arvalid |-> burst_beats != '0 && burst_beats <= CNT_W'(`DMA_MAX_BURST));

endmodule

`default_nettype wire

// ==== src/dma_subsystem.sv ====
// DMA subsystem top
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module dma_subsystem
  import dma_axi_pkg::*, dma_ctrl_pkg::*;
(
  input  wire logic                       aclk,
  input  wire logic                       reset,
  // APB control port
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [`DMA_APB_ADDR_W-1:0] paddr,
  input  wire logic [`DMA_APB_DATA_W-1:0] pwdata,
  output logic      [`DMA_APB_DATA_W-1:0] prdata,
  output logic                            pready,
  output logic                            pslverr,
  // AXI read address and data
  output logic      [`DMA_ADDR_W-1:0]     araddr,
  output logic      [`DMA_AXI_LEN_W-1:0]  arlen,
  output logic                            arvalid,
  input  wire logic                       arready,
  input  wire logic [`DMA_DATA_W-1:0]     rdata,
  input  wire logic [`DMA_RESP_W-1:0]     rresp,
  input  wire logic                       rlast,
  input  wire logic                       rvalid,
  output logic                            rready,
  // AXI write address, data and response
  output logic      [`DMA_ADDR_W-1:0]     awaddr,
  output logic      [`DMA_AXI_LEN_W-1:0]  awlen,
  output logic                            awvalid,
  input  wire logic                       awready,
  output logic      [`DMA_DATA_W-1:0]     wdata,
  output logic                            wlast,
  output logic                            wvalid,
  input  wire logic                       wready,
  input  wire logic [`DMA_RESP_W-1:0]     bresp,
  input  wire logic                       bvalid,
  output logic                            bready,
  // Interrupts
  output logic                            irq,
  output logic                            irq_abort
);

  dma_desc_t             desc;
  logic                  start;
  logic                  busy;
  logic                  done;
  logic                  error;
  axi_addr_t             ar;
  axi_addr_t             aw;
  axi_r_t                r;
  axi_w_t                w;
  axi_b_t                b;
  axi_w_t                buf_in;
  axi_w_t                buf_head;
  logic                  buf_push;
  logic                  buf_pop;
  logic [`DMA_CNT_W-1:0] buf_count;

  // --------------------------------------------------
  // Pin packing
  // --------------------------------------------------
  // Upper len bits tied low, bursts stay within 16 beats
  assign araddr = ar.addr;
  assign arlen  = `DMA_AXI_LEN_W'(ar.len);
  assign awaddr = aw.addr;
  assign awlen  = `DMA_AXI_LEN_W'(aw.len);
  assign wdata  = w.data;
  assign wlast  = w.last;
  assign r      = '{data: rdata, resp: rresp, last: rlast};
  assign b      = '{resp: bresp};

  dma_apb_regs u_regs (
    .aclk      (aclk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .busy      (busy),
    .done      (done),
    .error     (error),
    .start     (start),
    .desc      (desc),
    .irq       (irq),
    .irq_abort (irq_abort)
  );

  dma_engine u_engine (
    .aclk      (aclk),
    .reset     (reset),
    .start     (start),
    .desc      (desc),
    .busy      (busy),
    .done      (done),
    .error     (error),
    .ar        (ar),
    .arvalid   (arvalid),
    .arready   (arready),
    .r         (r),
    .rvalid    (rvalid),
    .rready    (rready),
    .aw        (aw),
    .awvalid   (awvalid),
    .awready   (awready),
    .w         (w),
    .wvalid    (wvalid),
    .wready    (wready),
    .b         (b),
    .bvalid    (bvalid),
    .bready    (bready),
    .buf_push  (buf_push),
    .buf_pop   (buf_pop),
    .buf_in    (buf_in),
    .buf_head  (buf_head),
    .buf_count (buf_count)
  );

  // One burst of read beats waiting for the write side
  dma_burst_buffer u_buffer (
    .aclk  (aclk),
    .reset (reset),
    .push  (buf_push),
    .din   (buf_in),
    .pop   (buf_pop),
    .head  (buf_head),
    .count (buf_count)
  );

endmodule

`default_nettype wire

// ==== tb/tb_dma_subsystem.sv ====
// DMA subsystem testbench
`timescale 1ns/10ps
`default_nettype none
`include "dma_settings.svh"

module tb_dma_subsystem
  import dma_ctrl_pkg::*;
();

  // 2048 words of slave memory
  localparam int MEM_AW    = 11;
  localparam int MEM_WORDS = 1 << MEM_AW;

  logic aclk, reset, psel, penable, pwrite, pready, pslverr;
  logic [`DMA_APB_ADDR_W-1:0] paddr;
  logic [`DMA_APB_DATA_W-1:0] pwdata, prdata;
  logic [`DMA_ADDR_W-1:0]     araddr, awaddr;
  logic [`DMA_AXI_LEN_W-1:0]  arlen, awlen;
  logic [`DMA_DATA_W-1:0]     rdata, wdata;
  logic [`DMA_RESP_W-1:0]     rresp, bresp;
  logic arvalid, arready, rvalid, rready, rlast, awvalid, awready;
  logic wvalid, wready, wlast, bvalid, bready, irq, irq_abort;

  // Slave model state
  logic [`DMA_DATA_W-1:0]    mem [MEM_WORDS];
  logic [31:0]               lfsr_q;
  logic [63:0]               rnd;
  logic                      ar_fire, r_fire, aw_fire, w_fire, b_fire;
  logic [`DMA_ADDR_W-1:0]    ar_addr_s, aw_addr_s, rd_addr, wr_addr;
  logic [`DMA_AXI_LEN_W-1:0] ar_len_s, aw_len_s, cur_len;
  logic [`DMA_AXI_LEN_W-1:0] exp_len [$];
  logic [`DMA_DATA_W-1:0]    w_data_s;
  logic                      w_last_s, wr_err, b_pending, rst_s;
  int                        rd_left, wr_left, ar_count;

  // Job list and per-job bookkeeping
  int                     fd, total_beats, wd_cycles, i, j, rem, blen;
  bit                     loaded;
  string                  line;
  logic [31:0]            f_src, f_dst, f_len, f_err, rd, addr;
  logic [31:0]            job_src [$], job_dst [$], job_len [$], job_err [$];
  logic [`DMA_DATA_W-1:0] src_snap [$];
  logic [`DMA_DATA_W-1:0] past_word, fill;
  logic                   err_exp, irq_en;
  dma_status_t            st_exp;

  dma_subsystem dut0 (.*);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // --------------------------------------------------
  // Random source and failure path
  // --------------------------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int nbits, output logic [63:0] val);
    int k;
    val = '0;
    for (k = 0; k < nbits; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val = {val[62:0], lfsr_q[0]};
    end
  endtask

  function automatic int word_index(input logic [`DMA_ADDR_W-1:0] a);
    return int'(a[MEM_AW+2:3]);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [`DMA_DATA_W-1:0] got,
                            input logic [`DMA_DATA_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_reg(input string name, input logic [`DMA_APB_DATA_W-1:0] got,
                           input logic [`DMA_APB_DATA_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_status(input string name, input dma_status_t got,
                              input dma_status_t exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_len(input string name, input logic [`DMA_AXI_LEN_W-1:0] got,
                           input logic [`DMA_AXI_LEN_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp)
      fail_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
  endtask

  // --------------------------------------------------
  // APB master
  // --------------------------------------------------
  // Setup phase then access phase with the response sampled mid-cycle
  task automatic apb_access(input logic wr, input logic [`DMA_APB_ADDR_W-1:0] a,
                            input logic [`DMA_APB_DATA_W-1:0] data, input logic exp_err,
                            output logic [`DMA_APB_DATA_W-1:0] rdata_o);
    @(posedge aclk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = data;
    @(posedge aclk);
    #1;
    penable = 1'b1;
    @(negedge aclk);
    rdata_o = prdata;
    check_bit("pready", pready, 1'b1);
    check_bit("pslverr", pslverr, exp_err);
    @(posedge aclk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`DMA_APB_ADDR_W-1:0] a,
                           input logic [`DMA_APB_DATA_W-1:0] data, input logic exp_err);
    logic [`DMA_APB_DATA_W-1:0] unused;
    apb_access(1'b1, a, data, exp_err, unused);
  endtask

  // --------------------------------------------------
  // AXI slave model
  // --------------------------------------------------
  initial begin : axi_slave
    arready = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = '0;
    rlast   = 1'b0;
    bvalid  = 1'b0;
    bresp   = '0;
    forever begin
      // Handshakes that complete at the coming edge
      @(negedge aclk);
      rst_s     = reset;
      ar_fire   = arvalid & arready;
      r_fire    = rvalid & rready;
      aw_fire   = awvalid & awready;
      w_fire    = wvalid & wready;
      b_fire    = bvalid & bready;
      ar_addr_s = araddr;
      ar_len_s  = arlen;
      aw_addr_s = awaddr;
      aw_len_s  = awlen;
      w_data_s  = wdata;
      w_last_s  = wlast;
      @(posedge aclk);
      #1;
      if (rst_s) begin
        {arready, awready, wready, rvalid, bvalid, b_pending} = '0;
        rd_left = 0;
        wr_left = 0;
      end else begin
        draw_bits(5, rnd);
        if (ar_fire) begin
          if (exp_len.size() == 0) fail_run("Read address handshake with no burst left");
          cur_len = exp_len.pop_front();
          check_len("arlen", ar_len_s, cur_len);
          ar_count++;
          rd_addr = ar_addr_s;
          rd_left = int'(ar_len_s) + 1;
        end
        if (r_fire) begin
          rd_addr = rd_addr + 8;
          rd_left--;
          rvalid  = 1'b0;
        end
        // Error region reads return zero data with SLVERR
        if (!rvalid && rd_left != 0 && rnd[3]) begin
          rvalid = 1'b1;
          rdata  = rd_addr[31] ? '0 : mem[word_index(rd_addr)];
          rresp  = rd_addr[31] ? 2'b10 : 2'b00;
          rlast  = (rd_left == 1);
        end
        if (aw_fire) begin
          check_len("awlen", aw_len_s, cur_len);
          wr_addr = aw_addr_s;
          wr_left = int'(aw_len_s) + 1;
          wr_err  = aw_addr_s[31];
        end
        if (w_fire) begin
          if (wr_left == 0) fail_run("Write beat outside a write burst");
          check_bit("wlast", w_last_s, wr_left == 1);
          if (!wr_err) mem[word_index(wr_addr)] = w_data_s;
          wr_addr = wr_addr + 8;
          wr_left--;
          if (wr_left == 0) b_pending = 1'b1;
        end
        if (b_fire) bvalid = 1'b0;
        if (b_pending && !bvalid && rnd[4]) begin
          bvalid    = 1'b1;
          bresp     = wr_err ? 2'b10 : 2'b00;
          b_pending = 1'b0;
        end
        arready = rnd[0];
        awready = rnd[1];
        wready  = rnd[2];
      end
    end
  end

  // Watchdog arms once the job file is read
  initial begin : watchdog
    wait (loaded);
    repeat (wd_cycles) @(posedge aclk);
    $display("Timeout: jobs did not finish within %0d cycles", wd_cycles);
    $display(">>> FAIL");
    $fatal(1, "watchdog expired");
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    lfsr_q  = 32'h6b84515a;
    total_beats = 0;
    loaded  = 1'b0;
    for (i = 0; i < MEM_WORDS; i++) begin
      draw_bits(64, fill);
      mem[i] = fill;
    end
    fd = $fopen("tb/dma_input.txt", "r");
    if (fd == 0) fail_run("Cannot open tb/dma_input.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#" &&
          $sscanf(line, "%h %h %h %h", f_src, f_dst, f_len, f_err) == 4) begin
        job_src.push_back(f_src);
        job_dst.push_back(f_dst);
        job_len.push_back(f_len);
        job_err.push_back(f_err);
        total_beats += int'(f_len);
      end
    end
    $fclose(fd);
    wd_cycles = total_beats * 40 + 2000;
    loaded = 1'b1;

    repeat (8) @(posedge aclk);
    #1;
    reset = 1'b0;

    // Unmapped offset faults on write and read
    apb_write(12'h014, 32'hdeadbeef, 1'b1);
    apb_access(1'b0, 12'h014, '0, 1'b1, rd);
    check_reg("unmapped read", rd, '0);

    for (j = 0; j < job_src.size(); j++) begin
      err_exp = job_err[j][0];
      irq_en  = j[0];
      src_snap.delete();
      for (i = 0; i < int'(job_len[j]); i++)
        src_snap.push_back(mem[word_index(job_src[j] + 32'(8 * i))]);
      addr = job_dst[j] + (job_len[j] << 3);
      past_word = mem[word_index(addr)];
      // Expected burst split
      exp_len.delete();
      ar_count = 0;
      rem = int'(job_len[j]);
      while (rem > 0) begin
        blen = (rem > `DMA_MAX_BURST) ? `DMA_MAX_BURST : rem;
        exp_len.push_back(`DMA_AXI_LEN_W'(blen - 1));
        rem -= blen;
      end

      apb_write(REG_SRC, job_src[j], 1'b0);
      apb_write(REG_DST, job_dst[j], 1'b0);
      apb_write(REG_LEN, job_len[j], 1'b0);
      apb_write(REG_CTRL, {30'd0, irq_en, 1'b1}, 1'b0);
      // Reconfig while busy is refused
      apb_write(REG_SRC, ~job_src[j], 1'b1);
      apb_access(1'b0, REG_SRC, '0, 1'b0, rd);
      check_reg("src register", rd, job_src[j]);

      do begin
        apb_access(1'b0, REG_STATUS, '0, 1'b0, rd);
      end while (rd[2]);
      st_exp.busy  = 1'b0;
      st_exp.done  = ~err_exp;
      st_exp.error = err_exp;
      check_status("status", dma_status_t'(rd[2:0]), st_exp);
      @(negedge aclk);
      check_bit("irq", irq, ~err_exp & irq_en);
      check_bit("irq_abort", irq_abort, err_exp);

      if (!err_exp) begin
        check_count("ar handshakes", ar_count, (int'(job_len[j]) + 15) / 16);
        for (i = 0; i < int'(job_len[j]); i++) begin
          addr = job_dst[j] + 32'(8 * i);
          check_word($sformatf("mem[%h]", addr), mem[word_index(addr)], src_snap[i]);
        end
        addr = job_dst[j] + (job_len[j] << 3);
        check_word("word past dst", mem[word_index(addr)], past_word);
      end

      // Clear both sticky flags
      apb_write(REG_STATUS, 32'h3, 1'b0);
      apb_access(1'b0, REG_STATUS, '0, 1'b0, rd);
      check_status("status cleared", dma_status_t'(rd[2:0]), '0);
      @(negedge aclk);
      check_bit("irq", irq, 1'b0);
      check_bit("irq_abort", irq_abort, 1'b0);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dma_copy.f ====
+incdir+src
src/dma_axi_pkg.sv
src/dma_ctrl_pkg.sv
src/dma_apb_regs.sv
src/dma_burst_buffer.sv
src/dma_engine.sv
src/dma_subsystem.sv
tb/tb_dma_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the DMA copy subsystem

VERILATOR ?= verilator
TOP       ?= tb_dma_subsystem
FILELIST  ?= dma_copy.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard src/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the output
run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/dma_input.txt ====
# Columns (hex): source address, destination address, beats, expected error flag
# Addresses at or above 80000000 answer with SLVERR
00000000 00002000 00000010 0
00000100 00002200 00000001 0
00000200 00002400 00000025 0
00000800 00002800 00000011 0
00000400 00003000 00000040 0
80000000 00003400 00000008 1
00000000 80001000 00000014 1
00001000 00003800 0000000f 0
00000900 00003c00 00000003 0
00001800 00003e00 00000020 0
